//--- logic/ControlPkg.sv
`default_nettype none

package ControlPkg;

	localparam int OpcodeWidth = 6;
	localparam int FunctWidth = 6;
	localparam int InstrWidth = 32;

	// primary opcodes, instruction bits 31:26
	localparam logic [OpcodeWidth-1:0] OpRType = 6'h00;
	localparam logic [OpcodeWidth-1:0] OpJ = 6'h02;
	localparam logic [OpcodeWidth-1:0] OpJal = 6'h03;
	localparam logic [OpcodeWidth-1:0] OpBeq = 6'h04;
	localparam logic [OpcodeWidth-1:0] OpBne = 6'h05;
	localparam logic [OpcodeWidth-1:0] OpAddi = 6'h08;
	localparam logic [OpcodeWidth-1:0] OpAddiu = 6'h09;
	localparam logic [OpcodeWidth-1:0] OpSlti = 6'h0A;
	localparam logic [OpcodeWidth-1:0] OpXori = 6'h0E;
	localparam logic [OpcodeWidth-1:0] OpLui = 6'h0F;
	localparam logic [OpcodeWidth-1:0] OpRte = 6'h10;
	localparam logic [OpcodeWidth-1:0] OpLw = 6'h23;
	localparam logic [OpcodeWidth-1:0] OpLb = 6'h24;
	localparam logic [OpcodeWidth-1:0] OpLh = 6'h25;
	localparam logic [OpcodeWidth-1:0] OpSw = 6'h2B;
	localparam logic [OpcodeWidth-1:0] OpSb = 6'h28;
	localparam logic [OpcodeWidth-1:0] OpSh = 6'h29;

	// funct field of R-type, bits 5:0
	localparam logic [FunctWidth-1:0] FnJr = 6'h08;
	localparam logic [FunctWidth-1:0] FnSlt = 6'h2A;
	localparam logic [FunctWidth-1:0] FnAddu = 6'h21;
	localparam logic [FunctWidth-1:0] FnSubu = 6'h23;

	typedef enum logic [4:0] {
		Fetch, FetchWait, FetchLatch, FetchSettle, Decode,
		RExec, RWrite, ImmExec, ImmWrite, XorExec,
		Lui, Beq, Bne, J, Jal, Jr,
		SltExec, SltWrite, SltiExec,
		LoadAddr, LoadRead, LoadWait, LoadCapture, LoadWrite,
		StoreAddr, StoreWrite,
		Trap, TrapWait, TrapJump, Rte,
		Halt
	} State_t;

	// shared by the MDR load size and the store size
	typedef enum logic [1:0] {
		Word = 2'd0,
		Half = 2'd1,
		Byte = 2'd2
	} AccessSize_t;

	typedef enum logic [1:0] {
		SrcBFour, SrcBRegB, SrcBImm, SrcBBranchOffset
	} AluSrcB_t;

	typedef enum logic [2:0] {
		AluAdd, AluSub, AluFunct, AluXor
	} AluOp_t;

	// memory address source
	typedef enum logic [1:0] {
		AddrPc, AddrAluOut, AddrOpcodeVector, AddrOverflowVector
	} AddrSel_t;

	// register file write data source
	typedef enum logic [2:0] {
		WbAluOut, WbMdr, WbUpperImm, WbZero, WbOne, WbReturnAddr
	} MemToReg_t;

	typedef enum logic [1:0] {
		DstRt, DstRd, DstRa
	} RegDst_t;

	typedef enum logic [2:0] {
		PcAluResult, PcAluOut, PcJumpTarget, PcTrapVector, PcEpc
	} PcSel_t;

endpackage

`default_nettype wire

//--- logic/InstrDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module InstrDecoder import ControlPkg::*; (
	input wire logic [InstrWidth-1:0] Instruction,
	input wire logic [OpcodeWidth-1:0] Op,
	input wire logic [FunctWidth-1:0] Funct,
	input wire logic OFlag,
	output State_t ExecState,
	output AccessSize_t AccessSize,
	output logic OverflowTrap
);

	logic overflowExempt;

	// first execute state after Decode
	always_comb begin
		ExecState = Trap; // unknown opcode
		if (Instruction == '0) begin
			ExecState = Fetch; // nop
		end else begin
			case (Op)
				OpRType: begin
					case (Funct)
						FnJr: ExecState = Jr;
						FnSlt: ExecState = SltExec;
						default: ExecState = RExec;
					endcase
				end
				OpJ: ExecState = J;
				OpJal: ExecState = Jal;
				OpBeq: ExecState = Beq;
				OpBne: ExecState = Bne;
				OpAddi: ExecState = ImmExec;
				OpAddiu: ExecState = ImmExec; // same path, differs only on overflow
				OpSlti: ExecState = SltiExec;
				OpXori: ExecState = XorExec;
				OpLui: ExecState = Lui;
				OpRte: ExecState = Rte;
				OpLw: ExecState = LoadAddr;
				OpLh: ExecState = LoadAddr;
				OpLb: ExecState = LoadAddr;
				OpSw: ExecState = StoreAddr;
				OpSh: ExecState = StoreAddr;
				OpSb: ExecState = StoreAddr;
				default: ExecState = Trap;
			endcase
		end
	end

	always_comb begin
		case (Op)
			OpLh: AccessSize = Half;
			OpSh: AccessSize = Half;
			OpLb: AccessSize = Byte;
			OpSb: AccessSize = Byte;
			default: AccessSize = Word; // lw, sw and don't care
		endcase
	end

	// unsigned arithmetic never traps
	assign overflowExempt = (Op == OpRType && (Funct == FnAddu || Funct == FnSubu))
		|| Op == OpAddiu;

	assign OverflowTrap = OFlag && !overflowExempt;

endmodule

`default_nettype wire

//--- logic/StateSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module StateSequencer import ControlPkg::*; #(
	parameter int MemWaitCycles = 1 // must be at least 1
) (
	input wire logic Clk,
	input wire logic Reset,
	input wire logic Break,
	input wire State_t ExecState,
	input wire AccessSize_t AccessSize,
	input wire logic OverflowTrap,
	output State_t State,
	output AccessSize_t LoadSize,
	output logic TrapIsOverflow
);

	localparam int CountWidth = (MemWaitCycles > 1) ? $clog2(MemWaitCycles) : 1;
	localparam logic [CountWidth-1:0] LastWait = CountWidth'(MemWaitCycles - 1);

	State_t nextState;
	logic [CountWidth-1:0] waitCount;
	logic inWait;
	logic waitDone;

	// one counter serves every memory wait
	assign inWait = State inside {FetchWait, LoadWait, TrapWait};
	assign waitDone = (waitCount == LastWait);

	always_comb begin
		case (State)
			Fetch: nextState = OverflowTrap ? Trap : FetchWait; // overflow of previous instr
			FetchWait: nextState = waitDone ? FetchLatch : FetchWait;
			FetchLatch: nextState = FetchSettle;
			FetchSettle: nextState = Decode;
			Decode: nextState = ExecState;
			RExec: nextState = RWrite;
			ImmExec: nextState = ImmWrite;
			XorExec: nextState = ImmWrite;
			SltExec: nextState = SltWrite;
			SltiExec: nextState = SltWrite;
			LoadAddr: nextState = LoadRead;
			LoadRead: nextState = LoadWait;
			LoadWait: nextState = waitDone ? LoadCapture : LoadWait;
			LoadCapture: nextState = LoadWrite;
			StoreAddr: nextState = StoreWrite;
			Trap: nextState = TrapWait;
			TrapWait: nextState = waitDone ? TrapJump : TrapWait;
			Halt: nextState = Halt; // only reset leaves
			default: nextState = Fetch; // single-cycle execute and write-back states
		endcase
		if (Break) begin
			nextState = Halt;
		end
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			State <= Fetch;
		end else begin
			State <= nextState;
		end
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			waitCount <= '0;
		end else if (inWait && !waitDone) begin
			waitCount <= waitCount + 1'b1;
		end else begin
			waitCount <= '0;
		end
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			LoadSize <= Word;
			TrapIsOverflow <= 1'b0;
		end else begin
			if (State == Decode) begin
				LoadSize <= AccessSize; // held through the load or store
			end
			if (nextState == Trap) begin
				TrapIsOverflow <= (State == Fetch); // Decode entry is a bad opcode
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/ControlDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module ControlDecoder import ControlPkg::*; (
	input wire State_t State,
	input wire AccessSize_t LoadSize,
	input wire logic TrapIsOverflow,
	input wire logic ZeroFlag,
	input wire logic LessFlag,
	output logic PCWrite,
	output PcSel_t PcSel,
	output AddrSel_t IorD,
	output logic MemWrite,
	output AccessSize_t StoreSize,
	output logic MdrLoad,
	output AccessSize_t MdrInSize,
	output logic IRWrite,
	output logic RegWrite,
	output RegDst_t RegDst,
	output MemToReg_t MemToReg,
	output logic AluSrcA,
	output AluSrcB_t AluSrcB,
	output AluOp_t AluOp,
	output logic ALUOutLoad,
	output logic AWrite,
	output logic BWrite,
	output logic EpcWrite
);

	always_comb begin
		PCWrite = 1'b0;
		PcSel = PcAluResult;
		IorD = AddrPc;
		MemWrite = 1'b0;
		StoreSize = Word;
		MdrLoad = 1'b0;
		MdrInSize = Word;
		IRWrite = 1'b0;
		RegWrite = 1'b0;
		RegDst = DstRt;
		MemToReg = WbAluOut;
		AluSrcA = 1'b0; // 0 is pc, 1 is register A
		AluSrcB = SrcBFour;
		AluOp = AluAdd;
		ALUOutLoad = 1'b0;
		AWrite = 1'b0;
		BWrite = 1'b0;
		EpcWrite = 1'b0;

		case (State)
			Fetch: begin
				ALUOutLoad = 1'b1; // pc + 4 into ALUOut
			end
			FetchLatch: begin
				IRWrite = 1'b1;
				PCWrite = 1'b1; // pc + 4 straight from the alu
			end
			Decode: begin
				AWrite = 1'b1;
				BWrite = 1'b1;
				AluSrcB = SrcBBranchOffset; // branch target ahead of time
				ALUOutLoad = 1'b1;
			end
			RExec: begin
				AluSrcA = 1'b1;
				AluSrcB = SrcBRegB;
				AluOp = AluFunct;
				ALUOutLoad = 1'b1;
			end
			RWrite: begin
				RegWrite = 1'b1;
				RegDst = DstRd;
			end
			ImmExec, LoadAddr, StoreAddr: begin
				AluSrcA = 1'b1;
				AluSrcB = SrcBImm;
				ALUOutLoad = 1'b1; // sum or effective address
				if (State == LoadAddr) begin
					MdrInSize = LoadSize;
				end
			end
			XorExec: begin
				AluSrcA = 1'b1;
				AluSrcB = SrcBImm;
				AluOp = AluXor;
				ALUOutLoad = 1'b1;
			end
			ImmWrite: begin
				RegWrite = 1'b1; // rt, from ALUOut
			end
			Lui: begin
				RegWrite = 1'b1;
				MemToReg = WbUpperImm;
			end
			Beq, Bne: begin
				AluSrcA = 1'b1;
				AluSrcB = SrcBRegB;
				AluOp = AluSub;
				PcSel = PcAluOut; // target computed in Decode
				PCWrite = (State == Beq) ? ZeroFlag : !ZeroFlag;
			end
			J: begin
				PCWrite = 1'b1;
				PcSel = PcJumpTarget;
			end
			Jal: begin
				PCWrite = 1'b1;
				PcSel = PcJumpTarget;
				RegWrite = 1'b1;
				RegDst = DstRa;
				MemToReg = WbReturnAddr;
			end
			Jr: begin
				AluSrcA = 1'b1;
				AluOp = AluFunct; // alu passes rs for the jr funct
				PCWrite = 1'b1;
			end
			SltExec, SltiExec: begin
				AluSrcA = 1'b1;
				AluSrcB = (State == SltExec) ? SrcBRegB : SrcBImm;
				AluOp = AluSub;
				ALUOutLoad = 1'b1;
			end
			SltWrite: begin
				RegWrite = 1'b1;
				RegDst = DstRd;
				MemToReg = LessFlag ? WbOne : WbZero;
			end
			LoadRead, LoadWait: begin
				IorD = AddrAluOut; // hold address during memory latency
			end
			LoadCapture: begin
				IorD = AddrAluOut;
				MdrLoad = 1'b1;
			end
			LoadWrite: begin
				RegWrite = 1'b1;
				MemToReg = WbMdr;
			end
			StoreWrite: begin
				IorD = AddrAluOut;
				MemWrite = 1'b1;
				StoreSize = LoadSize;
			end
			Trap: begin
				EpcWrite = 1'b1;
				IorD = TrapIsOverflow ? AddrOverflowVector : AddrOpcodeVector;
			end
			TrapWait: begin
				IorD = TrapIsOverflow ? AddrOverflowVector : AddrOpcodeVector;
			end
			TrapJump: begin
				PCWrite = 1'b1;
				PcSel = PcTrapVector; // handler address read from the vector
			end
			Rte: begin
				PCWrite = 1'b1;
				PcSel = PcEpc;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/ControlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module ControlUnit import ControlPkg::*; #(
	parameter int MemWaitCycles = 1
) (
	input wire logic Clk,
	input wire logic Reset,
	input wire logic Break,
	input wire logic [InstrWidth-1:0] Instruction,
	input wire logic OFlag,
	input wire logic ZeroFlag,
	input wire logic LessFlag,
	output logic PCWrite,
	output PcSel_t PcSel,
	output AddrSel_t IorD,
	output logic MemWrite,
	output AccessSize_t StoreSize,
	output logic MdrLoad,
	output AccessSize_t MdrInSize,
	output logic IRWrite,
	output logic RegWrite,
	output RegDst_t RegDst,
	output MemToReg_t MemToReg,
	output logic AluSrcA,
	output AluSrcB_t AluSrcB,
	output AluOp_t AluOp,
	output logic ALUOutLoad,
	output logic AWrite,
	output logic BWrite,
	output logic EpcWrite
);

	logic [OpcodeWidth-1:0] op;
	logic [FunctWidth-1:0] funct;
	State_t execState;
	AccessSize_t accessSize;
	logic overflowTrap;
	State_t state;
	AccessSize_t loadSize;
	logic trapIsOverflow;

	assign op = Instruction[31:26];
	assign funct = Instruction[5:0];

	InstrDecoder instrDecoder (
		.Instruction(Instruction),
		.Op(op),
		.Funct(funct),
		.OFlag(OFlag),
		.ExecState(execState),
		.AccessSize(accessSize),
		.OverflowTrap(overflowTrap)
	);

	StateSequencer #(
		.MemWaitCycles(MemWaitCycles)
	) stateSequencer (
		.Clk(Clk),
		.Reset(Reset),
		.Break(Break),
		.ExecState(execState),
		.AccessSize(accessSize),
		.OverflowTrap(overflowTrap),
		.State(state),
		.LoadSize(loadSize),
		.TrapIsOverflow(trapIsOverflow)
	);

	ControlDecoder controlDecoder (
		.State(state),
		.LoadSize(loadSize),
		.TrapIsOverflow(trapIsOverflow),
		.ZeroFlag(ZeroFlag),
		.LessFlag(LessFlag),
		.PCWrite(PCWrite),
		.PcSel(PcSel),
		.IorD(IorD),
		.MemWrite(MemWrite),
		.StoreSize(StoreSize),
		.MdrLoad(MdrLoad),
		.MdrInSize(MdrInSize),
		.IRWrite(IRWrite),
		.RegWrite(RegWrite),
		.RegDst(RegDst),
		.MemToReg(MemToReg),
		.AluSrcA(AluSrcA),
		.AluSrcB(AluSrcB),
		.AluOp(AluOp),
		.ALUOutLoad(ALUOutLoad),
		.AWrite(AWrite),
		.BWrite(BWrite),
		.EpcWrite(EpcWrite)
	);

endmodule

`default_nettype wire

//--- test/ControlUnit_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module ControlUnitAsserts import ControlPkg::*; #(
	parameter int MemWaitCycles = 1
) (
	input wire logic Clk,
	input wire logic Reset,
	input wire logic Break,
	input wire logic [InstrWidth-1:0] Instruction,
	input wire logic OFlag,
	input wire logic ZeroFlag,
	input wire logic LessFlag,
	input wire logic PCWrite,
	input wire PcSel_t PcSel,
	input wire AddrSel_t IorD,
	input wire logic MemWrite,
	input wire AccessSize_t StoreSize,
	input wire logic MdrLoad,
	input wire AccessSize_t MdrInSize,
	input wire logic IRWrite,
	input wire logic RegWrite,
	input wire RegDst_t RegDst,
	input wire MemToReg_t MemToReg,
	input wire logic AluSrcA,
	input wire AluSrcB_t AluSrcB,
	input wire logic ALUOutLoad,
	input wire AluOp_t AluOp,
	input wire logic AWrite,
	input wire logic BWrite,
	input wire logic EpcWrite
);

	localparam int W = MemWaitCycles;

	int errorCount = 0; // read by the testbench
	logic halted;
	logic [OpcodeWidth-1:0] op;
	logic [FunctWidth-1:0] funct;
	logic isNop, isRAlu, isAdd, isAddu, isLoad, isStore, isUnknown;
	logic anyEnable;

	assign op = Instruction[31:26];
	assign funct = Instruction[5:0];
	assign isNop = (Instruction == '0);
	assign isRAlu = op == OpRType && !isNop && funct != FnJr && funct != FnSlt;
	assign isAdd = isRAlu && funct != FnAddu && funct != FnSubu; // signed, may trap
	assign isAddu = isRAlu && funct == FnAddu;
	assign isLoad = op inside {OpLw, OpLh, OpLb};
	assign isStore = op inside {OpSw, OpSh, OpSb};
	assign isUnknown = !(op inside {OpRType, OpJ, OpJal, OpBeq, OpBne, OpAddi, OpAddiu,
		OpSlti, OpXori, OpLui, OpRte, OpLw, OpLb, OpLh, OpSw, OpSb, OpSh});
	assign anyEnable = PCWrite || MemWrite || RegWrite || IRWrite || EpcWrite || MdrLoad
		|| AWrite || BWrite || ALUOutLoad;

	// expected access size from the opcode
	function automatic AccessSize_t sizeOf(input logic [OpcodeWidth-1:0] code);
		if (code == OpLh || code == OpSh)
			return Half;
		if (code == OpLb || code == OpSb)
			return Byte;
		return Word;
	endfunction

	// a Break seen at a clock edge holds until reset
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			halted <= 1'b0;
		end else if (Break) begin
			halted <= 1'b1;
		end
	end

	fetchLatch: assert property (@(posedge Clk) disable iff (Reset)
		IRWrite |-> PCWrite && PcSel == PcAluResult && !AluSrcA && AluSrcB == SrcBFour
		&& !(MemWrite || RegWrite || EpcWrite || MdrLoad))
		else begin errorCount++; $error("MISMATCH at %0t: bad enables with IRWrite", $time); end

	nopQuiet: assert property (@(posedge Clk) disable iff (Reset || halted)
		(isNop && !IRWrite) |-> !(PCWrite || MemWrite || RegWrite || EpcWrite || MdrLoad))
		else begin errorCount++; $error("MISMATCH at %0t: write enable during nop", $time); end

	nopPeriod: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 (isNop && !OFlag) |-> ##(W+3) IRWrite)
		else begin errorCount++; $error("MISMATCH at %0t: nop period wrong", $time); end

	rTypeWrite: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 isRAlu |-> ##2 (ALUOutLoad && AluOp == AluFunct && AluSrcA
		&& AluSrcB == SrcBRegB)
		##1 (RegWrite && RegDst == DstRd && MemToReg == WbAluOut) ##1 !RegWrite)
		else begin errorCount++; $error("MISMATCH at %0t: R-type sequence", $time); end

	addiWrite: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 (op == OpAddi) |-> ##2 (ALUOutLoad && AluOp == AluAdd && AluSrcA
		&& AluSrcB == SrcBImm)
		##1 (RegWrite && RegDst == DstRt && MemToReg == WbAluOut) ##1 !RegWrite)
		else begin errorCount++; $error("MISMATCH at %0t: ADDI sequence", $time); end

	xoriWrite: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 (op == OpXori) |-> ##2 (ALUOutLoad && AluOp == AluXor && AluSrcA
		&& AluSrcB == SrcBImm)
		##1 (RegWrite && RegDst == DstRt && MemToReg == WbAluOut) ##1 !RegWrite)
		else begin errorCount++; $error("MISMATCH at %0t: XORI sequence", $time); end

	luiWrite: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 (op == OpLui) |-> ##2 (RegWrite && MemToReg == WbUpperImm))
		else begin errorCount++; $error("MISMATCH at %0t: LUI write", $time); end

	storeWrite: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 isStore |-> ##3 (MemWrite && IorD == AddrAluOut && StoreSize == sizeOf(op))
		##1 !MemWrite)
		else begin errorCount++; $error("MISMATCH at %0t: store write", $time); end

	loadRead: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 isLoad |-> ##2 (MdrInSize == sizeOf(op)) ##(W+2) MdrLoad
		##1 (RegWrite && MemToReg == WbMdr))
		else begin errorCount++; $error("MISMATCH at %0t: load sequence", $time); end

	beqBranch: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 (op == OpBeq) |-> ##2 (PCWrite == ZeroFlag && PcSel == PcAluOut))
		else begin errorCount++; $error("MISMATCH at %0t: BEQ branch", $time); end

	bneBranch: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 (op == OpBne) |-> ##2 (PCWrite == !ZeroFlag && PcSel == PcAluOut))
		else begin errorCount++; $error("MISMATCH at %0t: BNE branch", $time); end

	jumpTarget: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 (op == OpJ) |-> ##2 (PCWrite && PcSel == PcJumpTarget && !RegWrite))
		else begin errorCount++; $error("MISMATCH at %0t: J target", $time); end

	jalLink: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 (op == OpJal) |-> ##2 (PCWrite && PcSel == PcJumpTarget && RegWrite
		&& RegDst == DstRa && MemToReg == WbReturnAddr))
		else begin errorCount++; $error("MISMATCH at %0t: JAL link", $time); end

	jrJump: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 (op == OpRType && funct == FnJr && !isNop)
		|-> ##2 (PCWrite && PcSel == PcAluResult))
		else begin errorCount++; $error("MISMATCH at %0t: JR jump", $time); end

	sltResult: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 ((op == OpRType && funct == FnSlt && !isNop) || op == OpSlti)
		|-> ##3 (RegWrite && MemToReg == (LessFlag ? WbOne : WbZero)))
		else begin errorCount++; $error("MISMATCH at %0t: SLT result", $time); end

	opcodeTrap: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 isUnknown |-> ##2 (EpcWrite && IorD == AddrOpcodeVector)
		##(W+1) (PCWrite && PcSel == PcTrapVector))
		else begin errorCount++; $error("MISMATCH at %0t: opcode trap", $time); end

	overflowTrap: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 isAdd ##4 OFlag |=> (EpcWrite && IorD == AddrOverflowVector)
		##(W+1) (PCWrite && PcSel == PcTrapVector))
		else begin errorCount++; $error("MISMATCH at %0t: overflow trap", $time); end

	adduNoTrap: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 isAddu ##4 OFlag |=> !EpcWrite ##W IRWrite)
		else begin errorCount++; $error("MISMATCH at %0t: ADDU trapped", $time); end

	rteReturn: assert property (@(posedge Clk) disable iff (Reset || Break)
		IRWrite ##1 (op == OpRte) |-> ##2 (PCWrite && PcSel == PcEpc))
		else begin errorCount++; $error("MISMATCH at %0t: RTE return", $time); end

	haltQuiet: assert property (@(posedge Clk) disable iff (Reset)
		halted |-> !anyEnable)
		else begin errorCount++; $error("MISMATCH at %0t: enable high while halted", $time); end

	resetFetch: assert property (@(posedge Clk)
		$fell(Reset) |-> ##(W+1) IRWrite)
		else begin errorCount++; $error("MISMATCH at %0t: first fetch after reset", $time); end

endmodule

bind ControlUnit ControlUnitAsserts #(.MemWaitCycles(MemWaitCycles)) asserts (.*);

`default_nettype wire

//--- test/ControlUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

module ControlUnitTb import ControlPkg::*; ();

	localparam int MemWaitCycles = 2;
	localparam int ResetCycles = 10;
	localparam int InstrCount = 44; // upper bound over all tests
	localparam int WorstInstrCycles = 2 * MemWaitCycles + 12; // add, trap, refetch
	localparam int WatchdogCycles = 2 * (3 * ResetCycles + 20 + InstrCount * WorstInstrCycles);
	localparam int IrTimeout = 3 * MemWaitCycles + 20;

	logic Clk, Reset, Break, OFlag, ZeroFlag, LessFlag;
	logic [InstrWidth-1:0] Instruction;
	logic PCWrite, MemWrite, MdrLoad, IRWrite, RegWrite, AluSrcA;
	logic ALUOutLoad, AWrite, BWrite, EpcWrite;
	PcSel_t PcSel;
	AddrSel_t IorD;
	AccessSize_t StoreSize, MdrInSize;
	RegDst_t RegDst;
	MemToReg_t MemToReg;
	AluSrcB_t AluSrcB;
	AluOp_t AluOp;

	logic [31:0] fieldRng = 32'd63273; // register fields
	logic [31:0] flagRng = 32'd63273; // alu flags
	int tbErrors = 0;
	int testsRun = 0;
	int lastErrors = 0;

	ControlUnit #(.MemWaitCycles(MemWaitCycles)) DUT (.*);

	initial begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] rType(input logic [5:0] fn);
		fieldRng = xorshift(fieldRng);
		return {OpRType, fieldRng[14:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] code);
		fieldRng = xorshift(fieldRng);
		return {code, fieldRng[25:0]};
	endfunction

	// flags from the ALU change every cycle
	always @(negedge Clk) begin
		flagRng = xorshift(flagRng);
		ZeroFlag <= flagRng[3];
		LessFlag <= flagRng[9];
	end

	task automatic waitIrWrite();
		int n;
		n = 0;
		do begin
			@(negedge Clk);
			n++;
		end while (!IRWrite && n < IrTimeout);
		if (!IRWrite) begin
			$display("no instruction fetch within %0d cycles at %0t", IrTimeout, $time);
			tbErrors++;
		end
	endtask

	// the IR takes the new word at the end of the IRWrite cycle
	task automatic issue(input logic [31:0] instr);
		waitIrWrite();
		@(negedge Clk);
		Instruction = instr;
	endtask

	task automatic overflowAfter(input logic [31:0] instr);
		issue(instr);
		repeat (4) @(negedge Clk); // Fetch cycle after the write-back
		OFlag = 1'b1;
		@(negedge Clk);
		OFlag = 1'b0;
	endtask

	task automatic finishTest(input string name);
		int errs;
		issue('0);
		errs = DUT.asserts.errorCount + tbErrors;
		testsRun++;
		$display("test %0d %s done, %0d new failures", testsRun, name, errs - lastErrors);
		lastErrors = errs;
	endtask

	task automatic applyReset();
		Reset = 1'b1;
		repeat (ResetCycles) @(negedge Clk);
		Reset = 1'b0;
	endtask

	initial begin
		int total;
		Break = 1'b0;
		OFlag = 1'b0;
		ZeroFlag = 1'b0;
		LessFlag = 1'b0;
		Instruction = '0;
		applyReset();

		repeat (4) issue('0);
		finishTest("nop");

		issue(rType(6'h20));
		issue(rType(FnSubu));
		issue(iType(OpAddi));
		issue(iType(OpXori));
		issue(iType(OpLui));
		finishTest("alu");

		issue(iType(OpLw));
		issue(iType(OpLh));
		issue(iType(OpLb));
		issue(iType(OpSw));
		issue(iType(OpSh));
		issue(iType(OpSb));
		finishTest("memory");

		repeat (3) begin
			issue(iType(OpBeq));
			issue(iType(OpBne));
			issue(rType(FnSlt));
			issue(iType(OpSlti));
		end
		issue(iType(OpJ));
		issue(iType(OpJal));
		issue(rType(FnJr));
		finishTest("control flow");

		issue({6'h3F, 26'h155});
		overflowAfter(rType(6'h20));
		overflowAfter(rType(FnAddu));
		issue(iType(OpRte));
		finishTest("exceptions");

		issue('0);
		repeat (2) @(negedge Clk);
		Break = 1'b1;
		@(negedge Clk);
		Break = 1'b0;
		repeat (12) @(negedge Clk); // halt must stay quiet
		Instruction = '0;
		applyReset();
		repeat (3) issue('0);
		finishTest("break");

		total = DUT.asserts.errorCount + tbErrors;
		$display("tests run: %0d, failures: %0d", testsRun, total);
		if (total == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		repeat (WatchdogCycles) @(posedge Clk);
		$display("watchdog expired after %0d cycles, run did not finish", WatchdogCycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
logic/ControlPkg.sv
logic/InstrDecoder.sv
logic/StateSequencer.sv
logic/ControlDecoder.sv
logic/ControlUnit.sv
test/ControlUnit_asserts.sv
test/ControlUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= ControlUnitTb
FLAGS ?= --assert --timing
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f verilog.f
	out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)
